/* build.f */
logic/tpu_array_pkg.sv
logic/tpu_vpu_pkg.sv
logic/acc_stream_if.sv
logic/matmul_array.sv
logic/acc_fifo.sv
logic/activation_unit.sv
logic/tpu_datapath.sv
testbench/tb_clock_gen.sv
testbench/tpu_checker.sv
testbench/tpu_tb.sv

/* logic/acc_fifo.sv */
`timescale 1ns/1ps

module acc_fifo (
    input  logic       clk,
    input  logic       rst_n,
    acc_stream_if.sink   in_s,     // From the array
    acc_stream_if.source out_s     // To the activation unit
);
    import tpu_array_pkg::*;
    import tpu_vpu_pkg::*;

    logic [ACC_VEC_W-1:0]            mem_data [FIFO_DEPTH];   // Payload storage
    logic                            mem_last [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr, rd_ptr;
    logic [$clog2(FIFO_DEPTH+1)-1:0] count;                   // 0..FIFO_DEPTH entries
    logic wr_fire, rd_fire;

    assign in_s.ready  = (count != FIFO_DEPTH);   // Room for one more
    assign out_s.valid = (count != 0);
    assign out_s.data  = mem_data[rd_ptr];        // Head of queue
    assign out_s.last  = mem_last[rd_ptr];

    assign wr_fire = in_s.valid && in_s.ready;
    assign rd_fire = out_s.valid && out_s.ready;

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem_data[wr_ptr] <= in_s.data;
            mem_last[wr_ptr] <= in_s.last;
        end
    end

    // ======================================================================
    // Pointers and occupancy
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) wr_ptr <= (wr_ptr == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (rd_fire) rd_ptr <= (rd_ptr == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;         // Idle or simultaneous push / pop
            endcase
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= FIFO_DEPTH);

    // Stalled head must not move
    a_head_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_s.valid && !out_s.ready |=> out_s.valid && $stable(out_s.data)
                                        && $stable(out_s.last));

endmodule

/* logic/acc_stream_if.sv */
`timescale 1ns/1ps

interface acc_stream_if;
    import tpu_array_pkg::*;

    logic                 valid;       // Item present on data
    logic                 ready;       // Sink can take it this cycle
    logic [ACC_VEC_W-1:0] data;        // Three column sums
    logic                 last;        // Final vector of a batch

    // Producer side
    modport source (
        output valid, data, last,
        input  ready
    );

    // Consumer side
    modport sink (
        input  valid, data, last,
        output ready
    );

endinterface

/* logic/activation_unit.sv */
`timescale 1ns/1ps

module activation_unit (
    input  logic                            clk,
    input  logic                            rst_n,
    acc_stream_if.sink                      acc_in,
    input  logic                            relu_en,
    output logic                            res_valid,
    input  logic                            res_ready,
    output logic [tpu_array_pkg::VEC_W-1:0] res_data,   // Byte j = column j
    output logic                            res_last
);
    import tpu_array_pkg::*;
    import tpu_vpu_pkg::*;

    logic             acc_fire;
    logic [VEC_W-1:0] q_bytes;        // Quantized columns of the incoming item

    // ReLU, then shift, then clamp to int8
    function automatic logic [DATA_W-1:0] quantize(input logic signed [ACC_W-1:0] acc,
                                                   input logic relu);
        logic signed [ACC_W-1:0] v;
        v = acc;
        if (relu && v < 0) v = '0;
        v = v >>> OUT_SHIFT;
        if (v > Q_MAX)      return DATA_W'(Q_MAX);
        else if (v < Q_MIN) return DATA_W'(Q_MIN);
        else                return v[DATA_W-1:0];
    endfunction

    always_comb begin
        for (int j = 0; j < ARRAY_DIM; j++) begin
            q_bytes[j*DATA_W +: DATA_W] = quantize($signed(acc_in.data[j*ACC_W +: ACC_W]),
                                                   relu_en);
        end
    end

    // Take new item if output slot empty or draining now
    assign acc_in.ready = !res_valid || res_ready;
    assign acc_fire     = acc_in.valid && acc_in.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (acc_in.ready) begin
            res_valid <= acc_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_fire) begin
            res_data <= q_bytes;
            res_last <= acc_in.last;           // Flag stays with its item
        end
    end

    a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid && !res_ready |=> res_valid && $stable(res_data) && $stable(res_last));

endmodule

/* logic/matmul_array.sv */
`timescale 1ns/1ps

module matmul_array (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wt_valid,
    output logic                           wt_ready,
    input  logic [tpu_array_pkg::VEC_W-1:0] wt_data,   // One weight row, byte j = column j
    input  logic                           act_valid,
    output logic                           act_ready,
    input  logic [tpu_array_pkg::VEC_W-1:0] act_data,  // Byte i = row i
    input  logic                           act_last,
    acc_stream_if.source                   acc_out
);
    import tpu_array_pkg::*;

    logic signed [DATA_W-1:0]   wt_q   [ARRAY_DIM][ARRAY_DIM];  // Stationary weights [row][col]
    logic [$clog2(ARRAY_DIM)-1:0] wt_row;                       // Next row to load
    logic                       mat_loaded;                     // Full matrix seen since reset
    logic                       run_q;                          // High from first cycle after reset

    logic signed [2*DATA_W-1:0] prod_q [ARRAY_DIM][ARRAY_DIM];  // Stage 1 products
    logic                       s1_valid, s1_last;
    logic signed [ACC_W-1:0]    col_sum [ARRAY_DIM];            // Column sums of stage 1
    logic [ACC_VEC_W-1:0]       s2_data;
    logic                       s2_valid, s2_last;

    logic s1_adv, s2_adv;
    logic wt_fire, act_fire;
    logic [1:0] in_flight;                                      // Accepted, not yet handed on

    // ======================================================================
    // Handshake
    // ======================================================================

    assign s2_adv = !s2_valid || acc_out.ready;        // Stage 2 empties or is taken
    assign s1_adv = !s1_valid || s2_adv;

    // Weights only load into an empty pipeline
    assign wt_ready = run_q && !s1_valid && !s2_valid;

    // Pending weight beat wins over activations
    assign act_ready = mat_loaded && (wt_row == '0) && s1_adv && !wt_valid;

    assign wt_fire  = wt_valid && wt_ready;
    assign act_fire = act_valid && act_ready;

    // ======================================================================
    // Weight loading
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q      <= 1'b0;
            wt_row     <= '0;
            mat_loaded <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (wt_fire) begin
                if (wt_row == ARRAY_DIM - 1) begin
                    wt_row     <= '0;               // Matrix complete so wrap for next reload
                    mat_loaded <= 1'b1;
                end else begin
                    wt_row <= wt_row + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wt_fire) begin
            for (int j = 0; j < ARRAY_DIM; j++) begin
                wt_q[wt_row][j] <= $signed(wt_data[j*DATA_W +: DATA_W]);
            end
        end
    end

    // ======================================================================
    // Pipeline
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (s1_adv) s1_valid <= act_fire;
            if (s2_adv) s2_valid <= s1_valid;
        end
    end

    // Stage 1 product per cell of act byte i and weight (i, j)
    always_ff @(posedge clk) begin
        if (act_fire) begin
            for (int i = 0; i < ARRAY_DIM; i++) begin
                for (int j = 0; j < ARRAY_DIM; j++) begin
                    prod_q[i][j] <= $signed(act_data[i*DATA_W +: DATA_W]) * wt_q[i][j];
                end
            end
            s1_last <= act_last;
        end
    end

    // Sign-extended sum down each column
    always_comb begin
        for (int j = 0; j < ARRAY_DIM; j++) begin
            col_sum[j] = '0;
            for (int i = 0; i < ARRAY_DIM; i++) begin
                col_sum[j] = col_sum[j] + prod_q[i][j];
            end
        end
    end

    // Stage 2 registered sums
    always_ff @(posedge clk) begin
        if (s2_adv && s1_valid) begin
            for (int j = 0; j < ARRAY_DIM; j++) begin
                s2_data[j*ACC_W +: ACC_W] <= col_sum[j];
            end
            s2_last <= s1_last;
        end
    end

    assign acc_out.valid = s2_valid;
    assign acc_out.data  = s2_data;
    assign acc_out.last  = s2_last;

    // Items between activation accept and stream handoff
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + 2'(act_fire) - 2'(acc_out.valid && acc_out.ready);
        end
    end

    // Load and compute phases never overlap
    a_no_dual_accept: assert property (@(posedge clk) disable iff (!rst_n)
        !(wt_fire && act_fire));

    a_no_load_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        wt_fire |-> in_flight == 2'd0);

endmodule

/* logic/tpu_array_pkg.sv */
package tpu_array_pkg;

    // ======================================================================
    // Matrix unit geometry
    // ======================================================================

    localparam int ARRAY_DIM = 3;                  // Rows and columns of the MXU

    localparam int DATA_W = 8;                     // Signed activation / weight byte

    // ======================================================================
    // Accumulation words
    // ======================================================================

    localparam int ACC_W = 32;                     // One column sum

    // Three bytes packed, byte i in bits [i*8 +: 8]
    localparam int VEC_W = ARRAY_DIM * DATA_W;

    // Three column sums, column j in bits [j*32 +: 32]
    localparam int ACC_VEC_W = ARRAY_DIM * ACC_W;

endpackage

/* logic/tpu_datapath.sv */
`timescale 1ns/1ps

module tpu_datapath (
    input  logic                            clk,
    input  logic                            rst_n,

    // Weight rows
    input  logic                            wt_valid,
    output logic                            wt_ready,
    input  logic [tpu_array_pkg::VEC_W-1:0] wt_data,

    // Activation vectors
    input  logic                            act_valid,
    output logic                            act_ready,
    input  logic [tpu_array_pkg::VEC_W-1:0] act_data,
    input  logic                            act_last,

    // int8 results
    output logic                            res_valid,
    input  logic                            res_ready,
    output logic [tpu_array_pkg::VEC_W-1:0] res_data,
    output logic                            res_last,

    input  logic                            relu_en    // Sampled per result item
);

    // ======================================================================
    // Stage links
    // ======================================================================

    acc_stream_if u_arr_to_fifo ();     // Array sums into queue
    acc_stream_if u_fifo_to_act ();     // Queue head into post-processing

    matmul_array u_matmul_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .wt_valid  (wt_valid),
        .wt_ready  (wt_ready),
        .wt_data   (wt_data),
        .act_valid (act_valid),
        .act_ready (act_ready),
        .act_data  (act_data),
        .act_last  (act_last),
        .acc_out   (u_arr_to_fifo.source)
    );

    acc_fifo u_acc_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .in_s  (u_arr_to_fifo.sink),
        .out_s (u_fifo_to_act.source)
    );

    activation_unit u_activation_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .acc_in    (u_fifo_to_act.sink),
        .relu_en   (relu_en),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data),
        .res_last  (res_last)
    );

endmodule

/* logic/tpu_vpu_pkg.sv */
package tpu_vpu_pkg;

    // ======================================================================
    // Post-processing
    // ======================================================================

    localparam int OUT_SHIFT = 4;                  // Arithmetic right shift before clamp

    // int8 range
    localparam int Q_MAX = 127;
    localparam int Q_MIN = -128;

    // ======================================================================
    // Buffering
    // ======================================================================

    // Accumulation queue between array and activation unit
    localparam int FIFO_DEPTH = 4;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the TPU datapath testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module tpu_tb -Mdir "$OBJ_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator compile step failed"
    exit 1
fi

sim_out="$("./$OBJ_DIR/Vtpu_tb" 2>&1)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD = 8                       // Clock period in ns
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset low for two periods, released on a falling edge
    initial begin
        rst_n = 1'b0;
        #(2 * PERIOD);
        rst_n = 1'b1;
    end

endmodule

/* testbench/tpu_checker.sv */
`timescale 1ns/1ps

module tpu_checker (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            res_valid,
    input  logic                            res_ready,
    input  logic [tpu_array_pkg::VEC_W-1:0] res_data,
    input  logic                            res_last
);
    import tpu_array_pkg::*;

    logic [VEC_W-1:0] exp_data_q [$];             // Expected results, oldest first
    logic             exp_last_q [$];             // Matching last flags

    string cur_name;                              // Test in progress
    string first_err;                             // First problem seen in this test
    int    cur_errs;
    int    cur_count;                             // Results matched in this test
    int    results_seen;                          // Every output transfer since start
    int    tests_run;
    int    tests_failed;

    task automatic note_error(input string msg);
        if (cur_errs == 0) first_err = msg;
        cur_errs++;
    endtask

    task automatic open_test(input string name);
        cur_name  = name;
        first_err = "";
        cur_errs  = 0;
        cur_count = 0;
    endtask

    task automatic expect_result(input logic [VEC_W-1:0] data, input logic last);
        exp_data_q.push_back(data);
        exp_last_q.push_back(last);
    endtask

    // ======================================================================
    // Output handshake monitor
    // ======================================================================

    always @(posedge clk) begin
        logic [VEC_W-1:0] exp_d;
        logic             exp_l;
        if (rst_n && res_valid && res_ready) begin
            results_seen++;
            if (exp_data_q.size() == 0) begin
                note_error($sformatf("ERROR %s: extra result %06h arrived, none was expected",
                                     cur_name, res_data));
            end else begin
                exp_d = exp_data_q.pop_front();
                exp_l = exp_last_q.pop_front();
                if (res_data !== exp_d)
                    note_error($sformatf("MISMATCH %s result %0d: expected %06h, actual %06h",
                                         cur_name, cur_count, exp_d, res_data));
                if (exp_l && res_last !== 1'b1)
                    note_error($sformatf("ERROR %s: res_last missing on the final result",
                                         cur_name));
                if (!exp_l && res_last !== 1'b0)
                    note_error($sformatf("ERROR %s: res_last set early, on result %0d",
                                         cur_name, cur_count));
                cur_count++;
            end
        end
    end

    // One line per finished test
    task automatic close_test();
        if (exp_data_q.size() != 0)
            note_error($sformatf("ERROR %s: %0d results never arrived",
                                 cur_name, exp_data_q.size()));
        exp_data_q.delete();                      // Leftovers would shift the next test
        exp_last_q.delete();
        tests_run++;
        if (cur_errs == 0) begin
            $display("PASS %s: %0d results checked", cur_name, cur_count);
        end else begin
            tests_failed++;
            if (cur_errs > 1) $display("%s (%0d errors in this test)", first_err, cur_errs);
            else              $display("%s", first_err);
        end
    endtask

    task automatic print_counts();
        $display("Summary: %0d tests run, %0d passed, %0d failed, %0d results received",
                 tests_run, tests_run - tests_failed, tests_failed, results_seen);
    endtask

endmodule

/* testbench/tpu_patterns.hex */
// Per test: weight rows 0..2, relu flag, activations 0..3 (last one ends the test), results 0..3
// 24-bit words, byte k of a vector in bits [8k+7:8k]
// identity, relu off
000001 000100 010000 000000
302010 F0807F 41EF05 C05500
030201 FFF807 04FE00 FC0500
// mixed-sign weights, relu on
02FF01 FD0102 0103FF 000001
302010 0A28EC 1ECE64 7F7F7F
000A02 000503 170000 00170F
// large products, saturation to 127 and -128, relu off
40807F C0807F 01807F 000000
7F7F7F 808080 030201 009C64
07807F F87F80 FCD02F 7F0000
// reload with column rotation weights, relu off
100000 000010 001000 000000
332211 017F80 AB00FF 3CA55A
113322 80017F FFAB00 5A3CA5
// random stalls on both sides, relu on
010101 FF0002 04FE00 000001
102040 140AC0 807F7F 7F9C78
060208 000000 001717 2D0000

/* testbench/tpu_tb.sv */
`timescale 1ns/1ps

module tpu_tb;
    import tpu_array_pkg::*;

    localparam int NUM_TESTS       = 5;
    localparam int VECS            = 4;           // Activation vectors per test
    localparam int REC_WORDS       = 12;          // 3 weight rows, relu, 4 acts, 4 results
    localparam int CLK_PERIOD      = 8;
    localparam int CYCLES_PER_TEST = 200;         // Watchdog budget
    localparam int DRAIN_CYCLES    = 150;         // Wait bound for one test's results

    logic             clk, rst_n;
    logic             wt_valid, wt_ready;
    logic [VEC_W-1:0] wt_data;
    logic             act_valid, act_ready, act_last;
    logic [VEC_W-1:0] act_data;
    logic             res_valid, res_ready, res_last;
    logic [VEC_W-1:0] res_data;
    logic             relu_en;

    logic [VEC_W-1:0] pat_mem [NUM_TESTS*REC_WORDS];
    string            test_name [NUM_TESTS];
    logic [15:0]      lfsr_q;                     // Shared random state
    logic             bp_mode;                    // Random stalls on the output

    tb_clock_gen #(.PERIOD(CLK_PERIOD)) u_clock_gen (.clk(clk), .rst_n(rst_n));

    tpu_datapath u_tpu_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .wt_valid  (wt_valid),
        .wt_ready  (wt_ready),
        .wt_data   (wt_data),
        .act_valid (act_valid),
        .act_ready (act_ready),
        .act_data  (act_data),
        .act_last  (act_last),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data),
        .res_last  (res_last),
        .relu_en   (relu_en)
    );

    tpu_checker u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data),
        .res_last  (res_last)
    );

    // ======================================================================
    // Random bits, x^16 + x^14 + x^13 + x^11 + 1
    // ======================================================================

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bit(output logic b);
        lfsr_q = lfsr_next(lfsr_q);               // One step per bit
        b      = lfsr_q[0];
    endtask

    // Output side ready about a quarter of the time under back-pressure
    always @(negedge clk) begin
        logic b0, b1;
        if (bp_mode) begin
            take_bit(b0);
            take_bit(b1);
            res_ready = b0 & b1;
        end else begin
            res_ready = 1'b1;
        end
    end

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_weight(input logic [VEC_W-1:0] row);
        wt_valid = 1'b1;
        wt_data  = row;
        #1;                                       // Ready settles from registers and inputs
        while (!wt_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        wt_valid = 1'b0;
    endtask

    task automatic send_act(input logic [VEC_W-1:0] vec, input logic last);
        act_valid = 1'b1;
        act_data  = vec;
        act_last  = last;
        #1;
        while (!act_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        act_valid = 1'b0;
        act_last  = 1'b0;
    endtask

    task automatic wait_results(input int target);
        int waited;
        waited = 0;
        while (u_checker.results_seen < target && waited < DRAIN_CYCLES) begin
            @(negedge clk);
            waited++;
        end
    endtask

    // ======================================================================
    // Stimulus
    // ======================================================================

    initial begin
        int   base;
        logic gap;
        wt_valid  = 1'b0;
        wt_data   = '0;
        act_valid = 1'b0;
        act_data  = '0;
        act_last  = 1'b0;
        relu_en   = 1'b0;
        res_ready = 1'b1;
        bp_mode   = 1'b0;
        lfsr_q    = 16'd6017;
        test_name[0] = "identity";
        test_name[1] = "mixed_sign_relu";
        test_name[2] = "saturation";
        test_name[3] = "weight_reload";
        test_name[4] = "backpressure";
        $readmemh("testbench/tpu_patterns.hex", pat_mem);

        wait (rst_n === 1'b1);
        @(posedge clk);
        @(negedge clk);

        for (int t = 0; t < NUM_TESTS; t++) begin
            base    = t * REC_WORDS;
            bp_mode = (t == NUM_TESTS - 1);
            relu_en = pat_mem[base+3][0];         // Stable until the test drains
            u_checker.open_test(test_name[t]);
            for (int r = 0; r < ARRAY_DIM; r++) send_weight(pat_mem[base+r]);
            for (int v = 0; v < VECS; v++)
                u_checker.expect_result(pat_mem[base+4+VECS+v], v == VECS - 1);
            for (int v = 0; v < VECS; v++) begin
                if (bp_mode) begin
                    take_bit(gap);
                    if (gap) @(negedge clk);      // Idle cycle before this vector
                end
                send_act(pat_mem[base+4+v], v == VECS - 1);
            end
            wait_results((t + 1) * VECS);
            repeat (4) @(negedge clk);            // Window for stray results
            u_checker.close_test();
        end
        bp_mode = 1'b0;

        u_checker.print_counts();
        if (u_checker.tests_failed == 0 && u_checker.tests_run == NUM_TESTS) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not complete",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("Test failed");
        $finish;
    end

endmodule
